// File: dv/decode_input.txt
# W label value  register write (value in hex or R for a random word)
# D instr pc imm alu wb wben load store branch jump stall  decode and expected ID/EX fields
# F instr pc  flush with that instruction on the input / H instr pc n  busywait n cycles
# alu 0 ADD 1 SUB 4 SLTU 5 XOR 7 SRA 8 OR a PASS_B / wb 0 ALU 1 MEM 2 PC4
W 1 R
W 2 R
W 3 R
W 4 12345678
W 31 R
W 0 deadbeef
# LUI AUIPC JAL JALR BEQ BNE SW ADDI SRAI SUB SRA SLTU ORI ECALL
D 123450b7 00000100 12345000 a 0 1 0 0 0 0 0
D fffff117 00000104 fffff000 0 0 1 0 0 0 0 0
D 801ff0ef 00000108 fffff800 0 2 1 0 0 0 1 0
D ffc100e7 0000010c fffffffc 0 2 1 0 0 0 1 0
D 00208863 00000110 00000010 1 0 0 0 0 1 0 0
D fe419ce3 00000114 fffffff8 1 0 0 0 0 1 0 0
D fe41a623 00000118 ffffffec 0 0 0 0 1 0 0 0
D fff08393 0000011c ffffffff 0 0 1 0 0 0 0 0
D 40315413 00000120 00000403 7 0 1 0 0 0 0 0
D 404184b3 00000124 00000000 1 0 1 0 0 0 0 0
D 4020d533 00000128 00000000 7 0 1 0 0 0 0 0
D 00123633 0000012c 00000000 4 0 1 0 0 0 0 0
D 0f016693 00000130 000000f0 8 0 1 0 0 0 0 0
D 00000073 00000134 00000000 0 0 0 0 0 0 0 0
# XOR reading x0 after the write to x0
D 01f045b3 00000138 00000000 5 0 1 0 0 0 0 0
W 3 R
W 4 R
D 404184b3 0000013c 00000000 1 0 1 0 0 0 0 0
# Load-use through rs1 then through rs2
D 00c0a283 00000140 0000000c 0 1 1 1 0 0 0 0
D 00228333 00000144 00000000 0 0 1 0 0 0 0 1
D 00412403 00000148 00000004 0 1 1 1 0 0 0 0
D 0081a023 0000014c 00000000 0 0 0 0 1 0 0 1
# No stall for a load to x0 or an unread rs2 field
D 0000a003 00000150 00000000 0 1 1 1 0 0 0 0
D 000003b3 00000154 00000000 0 0 1 0 0 0 0 0
D 00412403 00000158 00000004 0 1 1 1 0 0 0 0
D 00818493 0000015c 00000008 0 0 1 0 0 0 0 0
# Flush on top of a pending load-use stall
D 00c0a283 00000160 0000000c 0 1 1 1 0 0 0 0
F 00228333 00000164
D 00228333 00000164 00000000 0 0 1 0 0 0 0 0
# Busywait keeps the ORI in ID/EX
D 0f016693 00000168 000000f0 8 0 1 0 0 0 0 0
H 00c0a283 0000016c 4
D 00123633 00000170 00000000 4 0 1 0 0 0 0 0

// File: tb.f
rtl/rv_decode_pkg.sv
rtl/main_decoder.sv
rtl/imm_gen.sv
rtl/regfile.sv
rtl/instruction_decode_stage.sv
dv/clk_gen.sv
dv/tb_top.sv

// File: Makefile
TOP = tb_top
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module instruction_decode_stage \
		rtl/rv_decode_pkg.sv rtl/main_decoder.sv rtl/imm_gen.sv \
		rtl/regfile.sv rtl/instruction_decode_stage.sv

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;
   import rv_decode_pkg::*;

   logic            clk, rst_n;
   logic [31:2]     instr, pc;
   logic            busywait, flush;
   logic            wr_en;
   logic [4:0]      wr_label;
   logic [31:0]     wr_data;
   logic            load_stall;
   logic [31:2]     pc_q;
   logic [31:0]     rs1_value, rs2_value, imm_value;
   alu_op_e         alu_op;
   wb_sel_e         wb_sel;
   logic            op1_sel, op2_sel, reg_wb_en;
   logic [4:0]      rd, rs1_label, rs2_label;
   logic [2:0]      funct3;
   logic            is_load, is_store, is_branch, is_jump;

   logic [31:0]     reg_model [32];         // Mirror of the register file
   logic [31:0]     rng_state;
   int              op_no;

   // Fields of the current vector line
   logic [31:0]     f_instr, f_pc, f_imm, f_value;
   logic [3:0]      f_alu;
   logic [1:0]      f_wb;
   logic            f_wben, f_ld, f_st, f_br, f_jp, f_stall;

   // What the ID/EX register should hold now
   logic [31:0]     exp_pc, exp_rs1, exp_rs2, exp_imm;
   alu_op_e         exp_alu;
   wb_sel_e         exp_wb;
   logic            exp_wben, exp_ld, exp_st, exp_br, exp_jp;
   logic            exp_op1, exp_op2;
   logic [4:0]      exp_rd, exp_rs1l, exp_rs2l;
   logic [2:0]      exp_f3;

   clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(10)) u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

   instruction_decode_stage #(.REG_COUNT(32)) DUT (
      .clk_i(clk), .rst_n_i(rst_n), .instr_i(instr), .pc_i(pc),
      .busywait_i(busywait), .flush_i(flush), .rd_wr_en_i(wr_en),
      .rd_label_i(wr_label), .rd_data_i(wr_data), .load_stall_o(load_stall),
      .pc_o(pc_q), .rs1_value_o(rs1_value), .rs2_value_o(rs2_value),
      .imm_value_o(imm_value), .alu_op_o(alu_op), .alu_op1_sel_o(op1_sel),
      .alu_op2_sel_o(op2_sel), .wb_sel_o(wb_sel), .reg_wb_en_o(reg_wb_en),
      .rd_o(rd), .rs1_label_o(rs1_label), .rs2_label_o(rs2_label),
      .funct3_o(funct3), .is_load_o(is_load), .is_store_o(is_store),
      .is_branch_o(is_branch), .is_jump_o(is_jump)
   );

   //////////////////////////////////////////////////
   // Failure reporting and compares
   //////////////////////////////////////////////////
   task automatic stop_run();
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic abort_run(input string msg);
      $display("ERROR %s", msg);
      stop_run();
   endtask

   task automatic check_word(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
      if (act_v !== exp_v) begin
         $display("CHECK FAILED %s expected %h actual %h", name, exp_v, act_v);
         stop_run();
      end
   endtask

   task automatic check_alu(input string name, input alu_op_e exp_v, input alu_op_e act_v);
      if (act_v !== exp_v) begin
         $display("CHECK FAILED %s expected %s (%0d) actual %s (%0d)",
                  name, exp_v.name(), exp_v, act_v.name(), act_v);
         stop_run();
      end
   endtask

   task automatic check_wb(input string name, input wb_sel_e exp_v, input wb_sel_e act_v);
      if (act_v !== exp_v) begin
         $display("CHECK FAILED %s expected %s (%0d) actual %s (%0d)",
                  name, exp_v.name(), exp_v, act_v.name(), act_v);
         stop_run();
      end
   endtask

   task automatic check_bit(input string name, input logic exp_v, input logic act_v);
      if (act_v !== exp_v) begin
         $display("CHECK FAILED %s expected %b actual %b", name, exp_v, act_v);
         stop_run();
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic void expect_bubble();
      exp_pc   = '0;
      exp_rs1  = '0;
      exp_rs2  = '0;
      exp_imm  = '0;
      exp_alu  = ALU_ADD;
      exp_wb   = WB_ALU;
      exp_wben = 1'b0;
      exp_ld   = 1'b0;
      exp_st   = 1'b0;
      exp_br   = 1'b0;
      exp_jp   = 1'b0;
      exp_op1  = 1'b0;
      exp_op2  = 1'b0;
      exp_rd   = '0;
      exp_rs1l = '0;
      exp_rs2l = '0;
      exp_f3   = '0;
   endfunction

   // RV32I field positions give labels and funct3
   function automatic void expect_decode();
      exp_pc   = {f_pc[31:2], 2'b00};
      exp_rs1  = reg_model[f_instr[19:15]];
      exp_rs2  = reg_model[f_instr[24:20]];
      exp_imm  = f_imm;
      exp_alu  = alu_op_e'(f_alu);
      exp_wb   = wb_sel_e'(f_wb);
      exp_wben = f_wben;
      exp_ld   = f_ld;
      exp_st   = f_st;
      exp_br   = f_br;
      exp_jp   = f_jp;
      // Operand A is the PC for JAL and AUIPC
      exp_op1  = (f_instr[6:2] == 5'b11011) || (f_instr[6:2] == 5'b00101);
      // Operand B is the immediate for all but OP, BRANCH and SYSTEM
      exp_op2  = f_instr[6:2] inside {5'b00000, 5'b01000, 5'b11011, 5'b11001,
                                      5'b00100, 5'b01101, 5'b00101};
      exp_rd   = f_instr[11:7];
      exp_rs1l = f_instr[19:15];
      exp_rs2l = f_instr[24:20];
      exp_f3   = f_instr[14:12];
   endfunction

   task automatic compare_outputs(input string tag);
      check_word({tag, " pc"}, exp_pc, {pc_q, 2'b00});
      check_word({tag, " rs1_value"}, exp_rs1, rs1_value);
      check_word({tag, " rs2_value"}, exp_rs2, rs2_value);
      check_word({tag, " imm"}, exp_imm, imm_value);
      check_alu({tag, " alu_op"}, exp_alu, alu_op);
      check_wb({tag, " wb_sel"}, exp_wb, wb_sel);
      check_bit({tag, " alu_op1_sel"}, exp_op1, op1_sel);
      check_bit({tag, " alu_op2_sel"}, exp_op2, op2_sel);
      check_bit({tag, " reg_wb_en"}, exp_wben, reg_wb_en);
      check_bit({tag, " is_load"}, exp_ld, is_load);
      check_bit({tag, " is_store"}, exp_st, is_store);
      check_bit({tag, " is_branch"}, exp_br, is_branch);
      check_bit({tag, " is_jump"}, exp_jp, is_jump);
      check_word({tag, " rd"}, 32'(exp_rd), 32'(rd));
      check_word({tag, " rs1_label"}, 32'(exp_rs1l), 32'(rs1_label));
      check_word({tag, " rs2_label"}, 32'(exp_rs2l), 32'(rs2_label));
      check_word({tag, " funct3"}, 32'(exp_f3), 32'(funct3));
   endtask

   //////////////////////////////////////////////////
   // One task per vector line kind
   //////////////////////////////////////////////////
   task automatic drive_inputs(input logic busy, input logic fl);
      instr    = f_instr[31:2];
      pc       = f_pc[31:2];
      busywait = busy;
      flush    = fl;
   endtask

   task automatic run_write(input logic [4:0] label, input logic [31:0] value);
      busywait = 1'b1;                     // ID/EX holds, only the file moves
      wr_en    = 1'b1;
      wr_label = label;
      wr_data  = value;
      @(negedge clk);
      wr_en = 1'b0;
      if (label != 5'd0) begin
         reg_model[label] = value;         // x0 stays zero
      end
   endtask

   task automatic run_decode(input string tag);
      int bubbles;
      drive_inputs(1'b0, 1'b0);
      #1;
      check_bit({tag, " load_stall"}, f_stall, load_stall);
      bubbles = 0;
      while (load_stall) begin             // Upstream keeps the instruction
         @(negedge clk);
         bubbles++;
         if (bubbles > 3) begin
            abort_run("load_stall_o stayed high after the bubble");
         end
         expect_bubble();
         compare_outputs({tag, " stall bubble"});
         #1;
      end
      check_word({tag, " bubble count"}, 32'(f_stall), 32'(bubbles));
      @(negedge clk);
      expect_decode();
      compare_outputs(tag);
   endtask

   task automatic run_flush(input string tag);
      drive_inputs(1'b1, 1'b1);            // Flush beats busywait
      @(negedge clk);
      flush = 1'b0;
      expect_bubble();
      compare_outputs({tag, " flush"});
   endtask

   task automatic run_hold(input string tag, input int cycles);
      drive_inputs(1'b1, 1'b0);
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk);
         compare_outputs($sformatf("%s hold %0d", tag, i));
      end
   endtask

   initial begin
      int    fd;
      int    code;
      int    waited;
      int    label;
      int    cycles;
      string kind;
      string vtext;
      string rest;
      string tag;

      instr     = '0;
      pc        = '0;
      busywait  = 1'b1;                    // Nothing decodes before the reset check
      flush     = 1'b0;
      wr_en     = 1'b0;
      wr_label  = '0;
      wr_data   = '0;
      rng_state = 32'd23000;
      op_no     = 0;
      for (int i = 0; i < 32; i++) begin
         reg_model[i] = '0;
      end

      waited = 0;
      while (rst_n !== 1'b1) begin
         @(negedge clk);
         waited++;
         if (waited > 40) begin
            abort_run("reset was never released");
         end
      end
      @(negedge clk);
      expect_bubble();
      compare_outputs("after reset");
      check_bit("after reset load_stall", 1'b0, load_stall);

      fd = $fopen("dv/decode_input.txt", "r");
      if (fd == 0) begin
         abort_run("could not open dv/decode_input.txt");
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, "%s", kind);
         if (code != 1) begin
            break;
         end
         if (kind == "#") begin
            code = $fgets(rest, fd);
         end else begin
            op_no++;
            tag = $sformatf("op %0d %s", op_no, kind);
            if (kind == "W") begin
               code = $fscanf(fd, "%d %s", label, vtext);
               if (code != 2) begin
                  abort_run({tag, " is not a complete write line"});
               end
               if (vtext == "R") begin
                  rng_state = xorshift32(rng_state);
                  f_value   = rng_state;
               end else if ($sscanf(vtext, "%h", f_value) != 1) begin
                  abort_run({tag, " has a value that is not hex"});
               end
               run_write(label[4:0], f_value);
            end else if (kind == "D") begin
               code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f_instr, f_pc,
                              f_imm, f_alu, f_wb, f_wben, f_ld, f_st, f_br, f_jp, f_stall);
               if (code != 11) begin
                  abort_run({tag, " is not a complete decode line"});
               end
               run_decode(tag);
            end else if (kind == "F") begin
               if ($fscanf(fd, "%h %h", f_instr, f_pc) != 2) begin
                  abort_run({tag, " is not a complete flush line"});
               end
               run_flush(tag);
            end else if (kind == "H") begin
               if ($fscanf(fd, "%h %h %d", f_instr, f_pc, cycles) != 3) begin
                  abort_run({tag, " is not a complete hold line"});
               end
               run_hold(tag, cycles);
            end else begin
               abort_run({tag, " has an unknown line kind"});
            end
         end
      end
      $fclose(fd);

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// File: dv/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 10
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // Release on a falling edge, clear of the sampling edge
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

// File: rtl/instruction_decode_stage.sv
`timescale 1ns/1ps

module instruction_decode_stage #(
   parameter int REG_COUNT = 32
) (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  logic [31:2]                     instr_i,
   input  logic [31:2]                     pc_i,
   input  logic                            busywait_i,
   input  logic                            flush_i,
   input  logic                            rd_wr_en_i,
   input  logic [4:0]                      rd_label_i,
   input  logic [rv_decode_pkg::XLEN-1:0]  rd_data_i,
   output logic                            load_stall_o,
   output logic [31:2]                     pc_o,
   output logic [rv_decode_pkg::XLEN-1:0]  rs1_value_o,
   output logic [rv_decode_pkg::XLEN-1:0]  rs2_value_o,
   output logic [rv_decode_pkg::XLEN-1:0]  imm_value_o,
   output rv_decode_pkg::alu_op_e          alu_op_o,
   output logic                            alu_op1_sel_o,
   output logic                            alu_op2_sel_o,
   output rv_decode_pkg::wb_sel_e          wb_sel_o,
   output logic                            reg_wb_en_o,
   output logic [4:0]                      rd_o,
   output logic [4:0]                      rs1_label_o,
   output logic [4:0]                      rs2_label_o,
   output logic [2:0]                      funct3_o,
   output logic                            is_load_o,
   output logic                            is_store_o,
   output logic                            is_branch_o,
   output logic                            is_jump_o
);
   import rv_decode_pkg::*;

   // Instruction fields
   logic [4:0] rd_label;
   logic [4:0] rs1_label;
   logic [4:0] rs2_label;
   logic [2:0] funct3;

   assign rd_label  = instr_i[11:7];
   assign rs1_label = instr_i[19:15];
   assign rs2_label = instr_i[24:20];
   assign funct3    = instr_i[14:12];

   alu_op_e         alu_op;
   wb_sel_e         wb_sel;
   imm_fmt_e        imm_fmt;
   logic            op1_sel, op2_sel, reg_wr_en;
   logic            is_load, is_store, is_branch, is_jump;
   logic            uses_rs1, uses_rs2;
   logic [XLEN-1:0] imm, rs1_value, rs2_value;

   main_decoder u_main_decoder (
      .opcode_i    (opcode_e'(instr_i[6:2])),
      .funct3_i    (funct3),
      .funct7_i    (instr_i[31:25]),
      .alu_op_o    (alu_op),
      .op1_sel_o   (op1_sel),
      .op2_sel_o   (op2_sel),
      .wb_sel_o    (wb_sel),
      .reg_wr_en_o (reg_wr_en),
      .is_load_o   (is_load),
      .is_store_o  (is_store),
      .is_branch_o (is_branch),
      .is_jump_o   (is_jump),
      .uses_rs1_o  (uses_rs1),
      .uses_rs2_o  (uses_rs2),
      .imm_fmt_o   (imm_fmt)
   );

   imm_gen u_imm_gen (
      .instr_i   (instr_i[31:7]),
      .imm_fmt_i (imm_fmt),
      .imm_o     (imm)
   );

   regfile #(.REG_COUNT(REG_COUNT)) u_regfile (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wr_en_i    (rd_wr_en_i),             // Writeback port
      .rd_i       (rd_label_i),
      .rd_data_i  (rd_data_i),
      .rs1_i      (rs1_label),
      .rs2_i      (rs2_label),
      .rs1_data_o (rs1_value),
      .rs2_data_o (rs2_value)
   );

   //////////////////////////////////////////////////
   // Load-use hazard against the load now in EX
   //////////////////////////////////////////////////
   assign load_stall_o = is_load_o && (rd_o != 5'd0) &&
                         ((uses_rs1 && rd_o == rs1_label) ||
                          (uses_rs2 && rd_o == rs2_label));

   logic load_en;                           // Register takes a new value this edge
   logic bubble;                            // ... and that value is a bubble

   assign load_en = flush_i || !busywait_i;
   assign bubble  = flush_i || load_stall_o;

   //////////////////////////////////////////////////
   // ID/EX register
   //////////////////////////////////////////////////
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pc_o          <= '0;
         rs1_value_o   <= '0;
         rs2_value_o   <= '0;
         imm_value_o   <= '0;
         alu_op_o      <= ALU_ADD;
         alu_op1_sel_o <= 1'b0;
         alu_op2_sel_o <= 1'b0;
         wb_sel_o      <= WB_ALU;
         reg_wb_en_o   <= 1'b0;
         rd_o          <= '0;
         rs1_label_o   <= '0;
         rs2_label_o   <= '0;
         funct3_o      <= '0;
         is_load_o     <= 1'b0;
         is_store_o    <= 1'b0;
         is_branch_o   <= 1'b0;
         is_jump_o     <= 1'b0;
      end else if (load_en) begin           // Busywait alone holds everything
         pc_o          <= bubble ? '0 : pc_i;
         rs1_value_o   <= bubble ? '0 : rs1_value;
         rs2_value_o   <= bubble ? '0 : rs2_value;
         imm_value_o   <= bubble ? '0 : imm;
         alu_op_o      <= bubble ? ALU_ADD : alu_op;
         alu_op1_sel_o <= !bubble && op1_sel;
         alu_op2_sel_o <= !bubble && op2_sel;
         wb_sel_o      <= bubble ? WB_ALU : wb_sel;
         reg_wb_en_o   <= !bubble && reg_wr_en;
         rd_o          <= bubble ? '0 : rd_label;
         rs1_label_o   <= bubble ? '0 : rs1_label;
         rs2_label_o   <= bubble ? '0 : rs2_label;
         funct3_o      <= bubble ? '0 : funct3;
         is_load_o     <= !bubble && is_load;     // Clears next cycle, one bubble per load
         is_store_o    <= !bubble && is_store;
         is_branch_o   <= !bubble && is_branch;
         is_jump_o     <= !bubble && is_jump;
      end
   end

   // A flushed slot must never write back
   a_flush_kills_wb: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      flush_i |=> !reg_wb_en_o
   );

   // A matching load lets in exactly one bubble
   a_one_bubble_per_load: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      load_stall_o && !busywait_i |=> !load_stall_o
   );

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps

module regfile #(
   parameter int REG_COUNT = 32
) (
   input  logic                            clk_i,
   input  logic                            rst_n_i,
   input  logic                            wr_en_i,
   input  logic [4:0]                      rd_i,
   input  logic [rv_decode_pkg::XLEN-1:0]  rd_data_i,
   input  logic [4:0]                      rs1_i,
   input  logic [4:0]                      rs2_i,
   output logic [rv_decode_pkg::XLEN-1:0]  rs1_data_o,
   output logic [rv_decode_pkg::XLEN-1:0]  rs2_data_o
);
   import rv_decode_pkg::*;

   localparam int IDX_W = $clog2(REG_COUNT);

   logic [XLEN-1:0] regs [REG_COUNT];
   logic            wr_ok;
   logic            rs1_ok;
   logic            rs2_ok;

   // x0 and labels past the top of the file never hit the array
   assign wr_ok  = wr_en_i && (rd_i != 5'd0) && (32'(rd_i) < REG_COUNT);
   assign rs1_ok = (rs1_i != 5'd0) && (32'(rs1_i) < REG_COUNT);
   assign rs2_ok = (rs2_i != 5'd0) && (32'(rs2_i) < REG_COUNT);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_ok) begin
         regs[rd_i[IDX_W-1:0]] <= rd_data_i;
      end
   end

   // No bypass, same-cycle read sees the old value
   assign rs1_data_o = rs1_ok ? regs[rs1_i[IDX_W-1:0]] : '0;
   assign rs2_data_o = rs2_ok ? regs[rs2_i[IDX_W-1:0]] : '0;

   // Writeback must stay inside the configured file (RV32E has 16)
   a_wr_label_in_range: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      wr_en_i |-> (32'(rd_i) < REG_COUNT)
   );

endmodule

// File: rtl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
   input  logic [31:7]                     instr_i,
   input  rv_decode_pkg::imm_fmt_e         imm_fmt_i,
   output logic [rv_decode_pkg::XLEN-1:0]  imm_o
);
   import rv_decode_pkg::*;

   logic sign;

   assign sign = instr_i[31];               // Sign bit is always bit 31

   always_comb begin
      case (imm_fmt_i)
         IMM_I: imm_o = {{(XLEN-11){sign}}, instr_i[30:20]};
         IMM_S: imm_o = {{(XLEN-11){sign}}, instr_i[30:25], instr_i[11:7]};
         IMM_B: begin
            // Branch offset, bit 0 implied zero
            imm_o = {{(XLEN-12){sign}}, instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
         end
         IMM_U: imm_o = {instr_i[31:12], {(XLEN-20){1'b0}}};
         IMM_J: begin
            imm_o = {{(XLEN-20){sign}}, instr_i[19:12], instr_i[20],
                     instr_i[30:21], 1'b0};
         end
         default: imm_o = '0;               // No immediate
      endcase
   end

endmodule

// File: rtl/main_decoder.sv
`timescale 1ns/1ps

module main_decoder (
   input  rv_decode_pkg::opcode_e  opcode_i,
   input  logic [2:0]              funct3_i,
   input  logic [6:0]              funct7_i,
   output rv_decode_pkg::alu_op_e  alu_op_o,
   output logic                    op1_sel_o,
   output logic                    op2_sel_o,
   output rv_decode_pkg::wb_sel_e  wb_sel_o,
   output logic                    reg_wr_en_o,
   output logic                    is_load_o,
   output logic                    is_store_o,
   output logic                    is_branch_o,
   output logic                    is_jump_o,
   output logic                    uses_rs1_o,
   output logic                    uses_rs2_o,
   output rv_decode_pkg::imm_fmt_e imm_fmt_o
);
   import rv_decode_pkg::*;

   logic    alt_op;                         // SUB / SRA encoding in funct7
   alu_op_e arith_op;

   assign alt_op = (funct7_i == 7'b0100000);

   // ALU operation for OP and OP_IMM
   always_comb begin
      case (funct3_i)
         3'b000:  arith_op = (alt_op && opcode_i == OPC_OP) ? ALU_SUB : ALU_ADD;
         3'b001:  arith_op = ALU_SLL;
         3'b010:  arith_op = ALU_SLT;
         3'b011:  arith_op = ALU_SLTU;
         3'b100:  arith_op = ALU_XOR;
         3'b101:  arith_op = alt_op ? ALU_SRA : ALU_SRL;   // SRAI shares the funct7 pattern
         3'b110:  arith_op = ALU_OR;
         default: arith_op = ALU_AND;
      endcase
   end

   //////////////////////////////////////////////////
   // Control fields per opcode
   //////////////////////////////////////////////////
   always_comb begin
      // Bubble values unless the opcode says otherwise
      alu_op_o    = ALU_ADD;
      op1_sel_o   = 1'b0;
      op2_sel_o   = 1'b0;
      wb_sel_o    = WB_ALU;
      reg_wr_en_o = 1'b0;
      is_load_o   = 1'b0;
      is_store_o  = 1'b0;
      is_branch_o = 1'b0;
      is_jump_o   = 1'b0;
      uses_rs1_o  = 1'b0;
      uses_rs2_o  = 1'b0;
      imm_fmt_o   = IMM_NONE;

      case (opcode_i)
         OPC_LOAD: begin
            op2_sel_o   = 1'b1;
            wb_sel_o    = WB_MEM;
            reg_wr_en_o = 1'b1;
            is_load_o   = 1'b1;
            uses_rs1_o  = 1'b1;
            imm_fmt_o   = IMM_I;
         end
         OPC_STORE: begin
            op2_sel_o   = 1'b1;
            is_store_o  = 1'b1;
            uses_rs1_o  = 1'b1;
            uses_rs2_o  = 1'b1;              // Store data
            imm_fmt_o   = IMM_S;
         end
         OPC_BRANCH: begin
            alu_op_o    = ALU_SUB;          // Compare by subtraction
            is_branch_o = 1'b1;
            uses_rs1_o  = 1'b1;
            uses_rs2_o  = 1'b1;
            imm_fmt_o   = IMM_B;
         end
         OPC_JAL: begin
            op1_sel_o   = 1'b1;             // PC + offset
            op2_sel_o   = 1'b1;
            wb_sel_o    = WB_PC4;
            reg_wr_en_o = 1'b1;
            is_jump_o   = 1'b1;
            imm_fmt_o   = IMM_J;
         end
         OPC_JALR: begin
            op2_sel_o   = 1'b1;             // rs1 + offset
            wb_sel_o    = WB_PC4;
            reg_wr_en_o = 1'b1;
            is_jump_o   = 1'b1;
            uses_rs1_o  = 1'b1;
            imm_fmt_o   = IMM_I;
         end
         OPC_OP_IMM: begin
            alu_op_o    = arith_op;
            op2_sel_o   = 1'b1;
            reg_wr_en_o = 1'b1;
            uses_rs1_o  = 1'b1;
            imm_fmt_o   = IMM_I;
         end
         OPC_OP: begin
            alu_op_o    = arith_op;
            reg_wr_en_o = 1'b1;
            uses_rs1_o  = 1'b1;
            uses_rs2_o  = 1'b1;
         end
         OPC_LUI: begin
            alu_op_o    = ALU_PASS_B;
            op2_sel_o   = 1'b1;
            reg_wr_en_o = 1'b1;
            imm_fmt_o   = IMM_U;
         end
         OPC_AUIPC: begin
            op1_sel_o   = 1'b1;
            op2_sel_o   = 1'b1;
            reg_wr_en_o = 1'b1;
            imm_fmt_o   = IMM_U;
         end
         default: ;                         // SYSTEM and unknown opcodes stay a bubble
      endcase
   end

endmodule

// File: rtl/rv_decode_pkg.sv
package rv_decode_pkg;

   localparam int XLEN = 32;                // Data path width

   //////////////////////////////////////////////////
   // Major opcodes, instruction bits 6:2
   //////////////////////////////////////////////////
   typedef enum logic [4:0] {
      OPC_LOAD   = 5'b00000,
      OPC_OP_IMM = 5'b00100,
      OPC_AUIPC  = 5'b00101,
      OPC_STORE  = 5'b01000,
      OPC_OP     = 5'b01100,
      OPC_LUI    = 5'b01101,
      OPC_BRANCH = 5'b11000,
      OPC_JALR   = 5'b11001,
      OPC_JAL    = 5'b11011,
      OPC_SYSTEM = 5'b11100
   } opcode_e;

   // ADD sits at zero so a cleared register reads as ADD
   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_SLL    = 4'd2,
      ALU_SLT    = 4'd3,
      ALU_SLTU   = 4'd4,
      ALU_XOR    = 4'd5,
      ALU_SRL    = 4'd6,
      ALU_SRA    = 4'd7,
      ALU_OR     = 4'd8,
      ALU_AND    = 4'd9,
      ALU_PASS_B = 4'd10                    // LUI, operand B straight through
   } alu_op_e;

   typedef enum logic [1:0] {
      WB_ALU = 2'd0,
      WB_MEM = 2'd1,
      WB_PC4 = 2'd2                         // Link address for jumps
   } wb_sel_e;

   //////////////////////////////////////////////////
   // Immediate layouts
   //////////////////////////////////////////////////
   typedef enum logic [2:0] {
      IMM_NONE = 3'd0,
      IMM_I    = 3'd1,
      IMM_S    = 3'd2,
      IMM_B    = 3'd3,
      IMM_U    = 3'd4,
      IMM_J    = 3'd5
   } imm_fmt_e;

endpackage
